// File: common/id_pkg.sv
`include "rv_defs.svh"

package id_pkg;

  // data path
  typedef logic [`XLEN-1:0] xlen_t;

  typedef logic [`INST_W-1:0] inst_t;

  // register file index
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

  // one-hot, bit positions in rv_defs.svh
  typedef logic [`ALU_W-1:0] alu_op_t;

  typedef logic [`BJ_W-1:0] bj_op_t;

  // memory access kinds
  typedef logic [`LOAD_W-1:0] load_op_t;

  typedef logic [`STORE_W-1:0] store_op_t;

  // which unit result goes back to rd
  typedef logic [`WB_W-1:0] wb_sel_t;

  typedef logic [`EXCP_W-1:0] excp_t;

  // operand sources for execute
  typedef logic [`OP1_W-1:0] op1_src_t;

  typedef logic [`OP2_W-1:0] op2_src_t;

  // alu immediate is I, S or U; jump offset is B, J or I
  typedef logic [`IMM_FMT_W-1:0] imm_fmt_t;

endpackage

// File: common/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// widths
`define XLEN        64
`define INST_W      32
`define REG_ADDR_W  5
`define CSR_ADDR_W  12

// major opcodes
`define OPC_LOAD      7'h03
`define OPC_OP_IMM    7'h13
`define OPC_AUIPC     7'h17
`define OPC_OP_IMM_W  7'h1b
`define OPC_STORE     7'h23
`define OPC_OP        7'h33
`define OPC_LUI       7'h37
`define OPC_OP_W      7'h3b
`define OPC_BRANCH    7'h63
`define OPC_JALR      7'h67
`define OPC_JAL       7'h6f
`define OPC_SYSTEM    7'h73

// function codes
`define FUNCT7_ZERO  7'h00
`define FUNCT7_ALT   7'h20
`define FUNCT6_ZERO  6'h00
`define FUNCT6_ALT   6'h10

// imm12 of the system instructions with funct3 zero
`define IMM_ECALL   12'h000
`define IMM_EBREAK  12'h001
`define IMM_MRET    12'h302

// alu operation, one-hot
`define ALU_W     12
`define ALU_ADD   0
`define ALU_SUB   1
`define ALU_SLT   2
`define ALU_SLTU  3
`define ALU_XOR   4
`define ALU_OR    5
`define ALU_AND   6
`define ALU_SLL   7
`define ALU_SRL   8
`define ALU_SRA   9
`define ALU_ANDN  10
`define ALU_WRI   11

// branch and jump kind, one-hot
`define BJ_W     8
`define BJ_BEQ   0
`define BJ_BNE   1
`define BJ_BLT   2
`define BJ_BGE   3
`define BJ_BLTU  4
`define BJ_BGEU  5
`define BJ_JALR  6
`define BJ_JAL   7

// load kind
`define LOAD_W  7
`define LD_LB   0
`define LD_LH   1
`define LD_LW   2
`define LD_LD   3
`define LD_LBU  4
`define LD_LHU  5
`define LD_LWU  6

// store kind
`define STORE_W  4
`define ST_SB    0
`define ST_SH    1
`define ST_SW    2
`define ST_SD    3

// write-back source
`define WB_W    3
`define WB_EXE  0
`define WB_MEM  1
`define WB_CSR  2

// exception cause
`define EXCP_W      2
`define EXCP_BRK    0
`define EXCP_ECALL  1

// op1 source, none set selects zero
`define OP1_W     3
`define OP1_RS1   0
`define OP1_PC    1
`define OP1_ZIMM  2

// op2 source
`define OP2_W     4
`define OP2_IMM   0
`define OP2_RS2   1
`define OP2_FOUR  2
`define OP2_CSR   3

// immediate format selects
`define IMM_FMT_W  3
`define AIMM_I     0
`define AIMM_S     1
`define AIMM_U     2
`define JIMM_B     0
`define JIMM_J     1
`define JIMM_I     2

`endif

// File: decode/inst_decoder.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module inst_decoder (
  input  logic              id_valid,
  input  id_pkg::inst_t     stage_inst,
  output id_pkg::reg_addr_t rs1_addr,
  output id_pkg::reg_addr_t rs2_addr,
  output logic              csr_rd_ena,
  output id_pkg::csr_addr_t csr_rd_addr,
  output id_pkg::alu_op_t   alu_op,
  output logic              is_word,
  output id_pkg::bj_op_t    bj_op,
  output id_pkg::load_op_t  load_op,
  output id_pkg::store_op_t store_op,
  output logic              mem_rd_ena,
  output logic              mem_wr_ena,
  output id_pkg::wb_sel_t   wb_sel,
  output logic              reg_wr_ena,
  output id_pkg::reg_addr_t reg_wr_addr,
  output logic              csr_wr_ena,
  output id_pkg::csr_addr_t csr_wr_addr,
  output id_pkg::excp_t     excp_info,
  output logic              excp_exit,
  output logic              inst_illegal,
  output id_pkg::op1_src_t  op1_src,
  output id_pkg::op2_src_t  op2_src,
  output id_pkg::imm_fmt_t  alu_imm_fmt,
  output id_pkg::imm_fmt_t  jmp_imm_fmt
);

  import id_pkg::*;

  logic [6:0] opcode;
  logic [7:0] f3;
  logic       f6_zero, f6_alt, f7_zero, f7_alt;
  csr_addr_t  imm12;
  reg_addr_t  rd;

  assign opcode  = stage_inst[6:0];
  // funct3 as one-hot
  assign f3      = 8'b1 << stage_inst[14:12];
  assign f6_zero = (stage_inst[31:26] == `FUNCT6_ZERO);
  assign f6_alt  = (stage_inst[31:26] == `FUNCT6_ALT);
  assign f7_zero = (stage_inst[31:25] == `FUNCT7_ZERO);
  assign f7_alt  = (stage_inst[31:25] == `FUNCT7_ALT);
  assign imm12   = stage_inst[31:20];
  assign rd      = stage_inst[11:7];

  logic op_load, op_imm, op_auipc, op_imm_w, op_store, op_reg;
  logic op_lui, op_reg_w, op_branch, op_jalr, op_jal, op_sys;

  assign op_load   = (opcode == `OPC_LOAD);
  assign op_imm    = (opcode == `OPC_OP_IMM);
  assign op_auipc  = (opcode == `OPC_AUIPC);
  assign op_imm_w  = (opcode == `OPC_OP_IMM_W);
  assign op_store  = (opcode == `OPC_STORE);
  assign op_reg    = (opcode == `OPC_OP);
  assign op_lui    = (opcode == `OPC_LUI);
  assign op_reg_w  = (opcode == `OPC_OP_W);
  assign op_branch = (opcode == `OPC_BRANCH);
  assign op_jalr   = (opcode == `OPC_JALR) & f3[0];
  assign op_jal    = (opcode == `OPC_JAL);
  assign op_sys    = (opcode == `OPC_SYSTEM);

  // immediate alu ops, shifts carry a 6-bit shamt
  logic addi, slli, slti, sltiu, xori, srli, srai, ori, andi;
  assign addi  = op_imm & f3[0];
  assign slli  = op_imm & f3[1] & f6_zero;
  assign slti  = op_imm & f3[2];
  assign sltiu = op_imm & f3[3];
  assign xori  = op_imm & f3[4];
  assign srli  = op_imm & f3[5] & f6_zero;
  assign srai  = op_imm & f3[5] & f6_alt;
  assign ori   = op_imm & f3[6];
  assign andi  = op_imm & f3[7];

  logic addiw, slliw, srliw, sraiw;
  assign addiw = op_imm_w & f3[0];
  assign slliw = op_imm_w & f3[1] & f7_zero;
  assign srliw = op_imm_w & f3[5] & f7_zero;
  assign sraiw = op_imm_w & f3[5] & f7_alt;

  logic add, sub, sll, slt, sltu, xor_r, srl, sra, or_r, and_r;
  assign add   = op_reg & f3[0] & f7_zero;
  assign sub   = op_reg & f3[0] & f7_alt;
  assign sll   = op_reg & f3[1] & f7_zero;
  assign slt   = op_reg & f3[2] & f7_zero;
  assign sltu  = op_reg & f3[3] & f7_zero;
  assign xor_r = op_reg & f3[4] & f7_zero;
  assign srl   = op_reg & f3[5] & f7_zero;
  assign sra   = op_reg & f3[5] & f7_alt;
  assign or_r  = op_reg & f3[6] & f7_zero;
  assign and_r = op_reg & f3[7] & f7_zero;

  logic addw, subw, sllw, srlw, sraw;
  assign addw = op_reg_w & f3[0] & f7_zero;
  assign subw = op_reg_w & f3[0] & f7_alt;
  assign sllw = op_reg_w & f3[1] & f7_zero;
  assign srlw = op_reg_w & f3[5] & f7_zero;
  assign sraw = op_reg_w & f3[5] & f7_alt;

  logic ecall, ebreak, mret;
  assign ecall  = op_sys & f3[0] & (imm12 == `IMM_ECALL);
  assign ebreak = op_sys & f3[0] & (imm12 == `IMM_EBREAK);
  assign mret   = op_sys & f3[0] & (imm12 == `IMM_MRET);

  logic csrrw, csrrs, csrrc, csrrwi, csrrsi, csrrci;
  assign csrrw  = op_sys & f3[1];
  assign csrrs  = op_sys & f3[2];
  assign csrrc  = op_sys & f3[3];
  assign csrrwi = op_sys & f3[5];
  assign csrrsi = op_sys & f3[6];
  assign csrrci = op_sys & f3[7];

  assign load_op  = {`LOAD_W{op_load}} & f3[6:0];
  assign store_op = {`STORE_W{op_store}} & f3[3:0];
  assign bj_op    = {op_jal, op_jalr, {f3[7:4], f3[1:0]} & {6{op_branch}}};

  logic load_vld, store_vld, branch_vld, csr_reg, csr_imm, csr_vld;
  logic imm_vld, imm_w_vld, reg_vld, reg_w_vld, exe_wb, inst_vld;
  assign load_vld   = |load_op;
  assign store_vld  = |store_op;
  assign branch_vld = |bj_op[`BJ_BGEU:`BJ_BEQ];
  assign csr_reg    = csrrw | csrrs | csrrc;
  assign csr_imm    = csrrwi | csrrsi | csrrci;
  assign csr_vld    = csr_reg | csr_imm;
  assign imm_vld    = addi | slli | slti | sltiu | xori | srli | srai | ori | andi;
  assign imm_w_vld  = addiw | slliw | srliw | sraiw;
  assign reg_vld    = add | sub | sll | slt | sltu | xor_r | srl | sra | or_r | and_r;
  assign reg_w_vld  = addw | subw | sllw | srlw | sraw;
  assign exe_wb     = imm_vld | imm_w_vld | reg_vld | reg_w_vld | op_lui | op_auipc
                    | op_jal | op_jalr;
  assign inst_vld   = exe_wb | load_vld | store_vld | branch_vld | csr_vld
                    | ecall | ebreak | mret;

  assign alu_op[`ALU_ADD]  = add | addi | addw | addiw | op_auipc | op_lui | load_vld
                           | store_vld | op_jal | op_jalr;
  assign alu_op[`ALU_SUB]  = sub | subw | branch_vld;
  assign alu_op[`ALU_SLT]  = slt | slti | bj_op[`BJ_BLT] | bj_op[`BJ_BGE];
  assign alu_op[`ALU_SLTU] = sltu | sltiu | bj_op[`BJ_BLTU] | bj_op[`BJ_BGEU];
  assign alu_op[`ALU_XOR]  = xor_r | xori | bj_op[`BJ_BEQ] | bj_op[`BJ_BNE];
  assign alu_op[`ALU_OR]   = or_r | ori | csrrs | csrrsi;
  assign alu_op[`ALU_AND]  = and_r | andi;
  assign alu_op[`ALU_SLL]  = sll | slli | sllw | slliw;
  assign alu_op[`ALU_SRL]  = srl | srli | srlw | srliw;
  assign alu_op[`ALU_SRA]  = sra | srai | sraw | sraiw;
  assign alu_op[`ALU_ANDN] = csrrc | csrrci;
  assign alu_op[`ALU_WRI]  = csrrw | csrrwi;
  assign is_word           = imm_w_vld | reg_w_vld;

  logic use_rs1, use_rs2;
  assign use_rs1  = load_vld | store_vld | imm_vld | imm_w_vld | reg_vld | reg_w_vld
                  | branch_vld | op_jalr | csr_reg;
  assign use_rs2  = store_vld | reg_vld | reg_w_vld | branch_vld;
  assign rs1_addr = use_rs1 ? stage_inst[19:15] : '0;
  assign rs2_addr = use_rs2 ? stage_inst[24:20] : '0;

  assign csr_rd_ena  = csr_vld;
  assign csr_rd_addr = csr_vld ? imm12 : '0;
  assign csr_wr_ena  = csr_vld;
  assign csr_wr_addr = csr_vld ? imm12 : '0;

  assign mem_rd_ena  = load_vld;
  assign mem_wr_ena  = store_vld;
  assign wb_sel      = {csr_vld, load_vld, exe_wb};
  assign reg_wr_ena  = |wb_sel;
  assign reg_wr_addr = reg_wr_ena ? rd : '0;

  assign excp_info[`EXCP_BRK]   = ebreak;
  assign excp_info[`EXCP_ECALL] = ecall;
  assign excp_exit              = mret;
  assign inst_illegal           = id_valid & ~inst_vld;

  // lui leaves op1 at zero
  assign op1_src[`OP1_RS1]  = use_rs1 & ~op_jalr;
  assign op1_src[`OP1_PC]   = op_auipc | op_jal | op_jalr;
  assign op1_src[`OP1_ZIMM] = csr_imm;

  assign op2_src[`OP2_IMM]  = load_vld | store_vld | imm_vld | imm_w_vld | op_lui | op_auipc;
  assign op2_src[`OP2_RS2]  = reg_vld | reg_w_vld | branch_vld;
  assign op2_src[`OP2_FOUR] = op_jal | op_jalr;
  assign op2_src[`OP2_CSR]  = csr_vld;

  assign alu_imm_fmt[`AIMM_I] = load_vld | imm_vld | imm_w_vld;
  assign alu_imm_fmt[`AIMM_S] = store_vld;
  assign alu_imm_fmt[`AIMM_U] = op_lui | op_auipc;

  assign jmp_imm_fmt[`JIMM_B] = branch_vld;
  assign jmp_imm_fmt[`JIMM_J] = op_jal;
  assign jmp_imm_fmt[`JIMM_I] = op_jalr;

endmodule

// File: decode/operand_gen.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module operand_gen (
  input  id_pkg::inst_t    stage_inst,
  input  id_pkg::xlen_t    stage_pc,
  input  id_pkg::xlen_t    rs1_data,
  input  id_pkg::xlen_t    rs2_data,
  input  id_pkg::xlen_t    csr_data,
  input  id_pkg::op1_src_t op1_src,
  input  id_pkg::op2_src_t op2_src,
  input  id_pkg::imm_fmt_t alu_imm_fmt,
  input  id_pkg::imm_fmt_t jmp_imm_fmt,
  output id_pkg::xlen_t    op1,
  output id_pkg::xlen_t    op2,
  output id_pkg::xlen_t    jmp_imm
);

  import id_pkg::*;

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;
  xlen_t zimm;
  xlen_t alu_imm;

  assign imm_i = {{(`XLEN-12){stage_inst[31]}}, stage_inst[31:20]};

  assign imm_s = {{(`XLEN-12){stage_inst[31]}}, stage_inst[31:25], stage_inst[11:7]};

  assign imm_b = {{(`XLEN-13){stage_inst[31]}}, stage_inst[31], stage_inst[7],
                  stage_inst[30:25], stage_inst[11:8], 1'b0};

  // upper immediate, also sign-extended to 64 bits
  assign imm_u = {{(`XLEN-32){stage_inst[31]}}, stage_inst[31:12], 12'b0};

  assign imm_j = {{(`XLEN-21){stage_inst[31]}}, stage_inst[31], stage_inst[19:12],
                  stage_inst[20], stage_inst[30:21], 1'b0};

  // csr immediate sits in the rs1 field
  assign zimm = {{(`XLEN-5){1'b0}}, stage_inst[19:15]};

  // all selects are one-hot, so and-or muxing is enough
  assign alu_imm = ({`XLEN{alu_imm_fmt[`AIMM_I]}} & imm_i)
                 | ({`XLEN{alu_imm_fmt[`AIMM_S]}} & imm_s)
                 | ({`XLEN{alu_imm_fmt[`AIMM_U]}} & imm_u);

  assign op1 = ({`XLEN{op1_src[`OP1_RS1]}}  & rs1_data)
             | ({`XLEN{op1_src[`OP1_PC]}}   & stage_pc)
             | ({`XLEN{op1_src[`OP1_ZIMM]}} & zimm);

  assign op2 = ({`XLEN{op2_src[`OP2_IMM]}}  & alu_imm)
             | ({`XLEN{op2_src[`OP2_RS2]}}  & rs2_data)
             | ({`XLEN{op2_src[`OP2_FOUR]}} & xlen_t'(4))
             | ({`XLEN{op2_src[`OP2_CSR]}}  & csr_data);

  // jalr offset is added to rs1 in execute
  assign jmp_imm = ({`XLEN{jmp_imm_fmt[`JIMM_B]}} & imm_b)
                 | ({`XLEN{jmp_imm_fmt[`JIMM_J]}} & imm_j)
                 | ({`XLEN{jmp_imm_fmt[`JIMM_I]}} & imm_i);

endmodule

// File: project.f
+incdir+common
common/id_pkg.sv
src/id_pipe_reg.sv
decode/inst_decoder.sv
decode/operand_gen.sv
src/id_stage.sv
test/id_stage_chk.sv
test/id_stage_tb.sv

// File: src/id_pipe_reg.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module id_pipe_reg (
  input  logic          clk,
  input  logic          rst,
  input  logic          if_to_id_valid,
  input  id_pkg::xlen_t if_to_id_pc,
  input  id_pkg::inst_t if_to_id_inst,
  input  logic          ex_allowin,
  input  logic          bj_flush,
  output logic          id_allowin,
  output logic          id_to_ex_valid,
  output logic          id_valid,
  output id_pkg::xlen_t stage_pc,
  output id_pkg::inst_t stage_inst
);

  import id_pkg::*;

  xlen_t pc_q;
  inst_t inst_q;

  // decode always finishes in one cycle
  assign id_allowin     = ~id_valid | ex_allowin;
  assign id_to_ex_valid = id_valid & ~bj_flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
    end else if (id_allowin) begin
      id_valid <= if_to_id_valid;
    end else if (bj_flush) begin
      // stalled and flushed
      id_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (if_to_id_valid && id_allowin) begin
      pc_q   <= if_to_id_pc;
      inst_q <= if_to_id_inst;
    end
  end

  assign stage_pc = pc_q;
  // all-zero word decodes to nothing
  assign stage_inst = id_valid ? inst_q : '0;

endmodule

// File: src/id_stage.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module id_stage (
  input  logic              clk,
  input  logic              rst,

  input  logic              if_to_id_valid,
  input  id_pkg::xlen_t     if_to_id_pc,
  input  id_pkg::inst_t     if_to_id_inst,
  output logic              id_allowin,
  input  logic              ex_allowin,
  input  logic              bj_flush,

  input  id_pkg::xlen_t     rs1_data,
  input  id_pkg::xlen_t     rs2_data,
  input  id_pkg::xlen_t     csr_data,
  output id_pkg::reg_addr_t rs1_addr,
  output id_pkg::reg_addr_t rs2_addr,
  output logic              csr_rd_ena,
  output id_pkg::csr_addr_t csr_rd_addr,

  output logic              id_to_ex_valid,
  output id_pkg::xlen_t     id_to_ex_pc,
  output id_pkg::xlen_t     op1,
  output id_pkg::xlen_t     op2,
  output id_pkg::xlen_t     jmp_imm,
  output id_pkg::alu_op_t   alu_op,
  output logic              is_word,
  output id_pkg::bj_op_t    bj_op,
  output id_pkg::load_op_t  load_op,
  output id_pkg::store_op_t store_op,
  output logic              mem_rd_ena,
  output logic              mem_wr_ena,
  output id_pkg::wb_sel_t   wb_sel,
  output logic              reg_wr_ena,
  output id_pkg::reg_addr_t reg_wr_addr,
  output logic              csr_wr_ena,
  output id_pkg::csr_addr_t csr_wr_addr,
  output id_pkg::excp_t     excp_info,
  output logic              excp_exit,
  output logic              inst_illegal
);

  import id_pkg::*;

  logic     id_valid;
  xlen_t    stage_pc;
  inst_t    stage_inst;
  op1_src_t op1_src;
  op2_src_t op2_src;
  imm_fmt_t alu_imm_fmt;
  imm_fmt_t jmp_imm_fmt;

  assign id_to_ex_pc = stage_pc;

  id_pipe_reg u_pipe_reg (
    .clk            (clk),
    .rst            (rst),
    .if_to_id_valid (if_to_id_valid),
    .if_to_id_pc    (if_to_id_pc),
    .if_to_id_inst  (if_to_id_inst),
    .ex_allowin     (ex_allowin),
    .bj_flush       (bj_flush),
    .id_allowin     (id_allowin),
    .id_to_ex_valid (id_to_ex_valid),
    .id_valid       (id_valid),
    .stage_pc       (stage_pc),
    .stage_inst     (stage_inst)
  );

  inst_decoder u_decoder (
    .id_valid     (id_valid),
    .stage_inst   (stage_inst),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .csr_rd_ena   (csr_rd_ena),
    .csr_rd_addr  (csr_rd_addr),
    .alu_op       (alu_op),
    .is_word      (is_word),
    .bj_op        (bj_op),
    .load_op      (load_op),
    .store_op     (store_op),
    .mem_rd_ena   (mem_rd_ena),
    .mem_wr_ena   (mem_wr_ena),
    .wb_sel       (wb_sel),
    .reg_wr_ena   (reg_wr_ena),
    .reg_wr_addr  (reg_wr_addr),
    .csr_wr_ena   (csr_wr_ena),
    .csr_wr_addr  (csr_wr_addr),
    .excp_info    (excp_info),
    .excp_exit    (excp_exit),
    .inst_illegal (inst_illegal),
    .op1_src      (op1_src),
    .op2_src      (op2_src),
    .alu_imm_fmt  (alu_imm_fmt),
    .jmp_imm_fmt  (jmp_imm_fmt)
  );

  operand_gen u_operand_gen (
    .stage_inst  (stage_inst),
    .stage_pc    (stage_pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .csr_data    (csr_data),
    .op1_src     (op1_src),
    .op2_src     (op2_src),
    .alu_imm_fmt (alu_imm_fmt),
    .jmp_imm_fmt (jmp_imm_fmt),
    .op1         (op1),
    .op2         (op2),
    .jmp_imm     (jmp_imm)
  );

endmodule

// File: test/id_stage_chk.sv
`timescale 1ns/1ps

module id_stage_chk (
  input logic          clk,
  input logic          rst,
  input logic          if_to_id_valid,
  input id_pkg::xlen_t if_to_id_pc,
  input logic          ex_allowin,
  input logic          bj_flush,
  input logic          id_allowin,
  input logic          id_to_ex_valid,
  input logic          id_valid,
  input id_pkg::xlen_t stage_pc,
  input id_pkg::inst_t stage_inst
);

  assert property (@(posedge clk) rst |=> !id_valid)
    else $error("stage valid still set after a reset edge");

  // a flush while stalled empties the stage
  assert property (@(posedge clk) disable iff (rst)
    bj_flush && !id_allowin |=> !id_valid && !id_to_ex_valid)
    else $error("flushed stage still valid after the next edge");

  // stalled stage keeps its contents
  assert property (@(posedge clk) disable iff (rst)
    id_valid && !ex_allowin && !bj_flush |=>
      id_valid && $stable(stage_pc) && $stable(stage_inst))
    else $error("stage contents changed under back-pressure");

  // empty stage takes the word offered by fetch
  assert property (@(posedge clk) disable iff (rst)
    !id_valid && if_to_id_valid |=> id_valid && stage_pc == $past(if_to_id_pc))
    else $error("empty stage did not take the offered instruction");

endmodule

bind id_pipe_reg id_stage_chk u_chk (
  .clk            (clk),
  .rst            (rst),
  .if_to_id_valid (if_to_id_valid),
  .if_to_id_pc    (if_to_id_pc),
  .ex_allowin     (ex_allowin),
  .bj_flush       (bj_flush),
  .id_allowin     (id_allowin),
  .id_to_ex_valid (id_to_ex_valid),
  .id_valid       (id_valid),
  .stage_pc       (stage_pc),
  .stage_inst     (stage_inst)
);

// File: test/id_stage_tb.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module id_stage_tb;

  import id_pkg::*;

  // operand source codes used by the table
  localparam int O_ZERO = 0, O_RS1 = 1, O_PC = 2, O_ZIMM = 3, O_IMMI = 4, O_IMMS = 5,
                 O_IMMU = 6, O_IMMB = 7, O_IMMJ = 8, O_RS2 = 9, O_FOUR = 10, O_CSR = 11;

  // flag bits from the top are excp_info[1:0], excp_exit, illegal, csr rd/wr, reg_wr,
  // mem_wr, mem_rd and is_word
  typedef struct packed {
    inst_t      inst;
    alu_op_t    alu;
    bj_op_t     bj;
    load_op_t   ld;
    store_op_t  st;
    wb_sel_t    wb;
    logic [8:0] flags;
    logic [3:0] op1;
    logic [3:0] op2;
    logic [3:0] jmp;
  } row_t;

  logic      clk = 1'b0;
  logic      rst;
  logic      if_to_id_valid;
  xlen_t     if_to_id_pc;
  inst_t     if_to_id_inst;
  logic      id_allowin;
  logic      ex_allowin;
  logic      bj_flush;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  xlen_t     csr_data;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  logic      csr_rd_ena;
  csr_addr_t csr_rd_addr;
  logic      id_to_ex_valid;
  xlen_t     id_to_ex_pc;
  xlen_t     op1;
  xlen_t     op2;
  xlen_t     jmp_imm;
  alu_op_t   alu_op;
  logic      is_word;
  bj_op_t    bj_op;
  load_op_t  load_op;
  store_op_t store_op;
  logic      mem_rd_ena;
  logic      mem_wr_ena;
  wb_sel_t   wb_sel;
  logic      reg_wr_ena;
  reg_addr_t reg_wr_addr;
  logic      csr_wr_ena;
  csr_addr_t csr_wr_addr;
  excp_t     excp_info;
  logic      excp_exit;
  logic      inst_illegal;

  row_t   rows[$];
  logic   table_ready = 1'b0;
  int     errors = 0;
  int     checks = 0;
  int     cur_row = 0;
  integer seed;

  id_stage uut (.*);

  always #4 clk = ~clk;

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h (row %0d)", name, got, exp, cur_row);
    end
  endtask

  // immediates follow the RV64I encoding formats
  function automatic xlen_t expect_operand(input logic [3:0] src, input inst_t w,
                                           input xlen_t pc);
    case (src)
      O_RS1:   return rs1_data;
      O_PC:    return pc;
      O_ZIMM:  return xlen_t'(w[19:15]);
      O_IMMI:  return {{52{w[31]}}, w[31:20]};
      O_IMMS:  return {{52{w[31]}}, w[31:25], w[11:7]};
      O_IMMU:  return {{32{w[31]}}, w[31:12], 12'h000};
      O_IMMB:  return {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      O_IMMJ:  return {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      O_RS2:   return rs2_data;
      O_FOUR:  return 64'd4;
      O_CSR:   return csr_data;
      default: return '0;
    endcase
  endfunction

  task automatic add_row(input inst_t inst, input alu_op_t alu, input bj_op_t bj,
                         input load_op_t ld, input store_op_t st, input wb_sel_t wb,
                         input logic [8:0] flags, input logic [3:0] s1, input logic [3:0] s2,
                         input logic [3:0] sj);
    rows.push_back({inst, alu, bj, ld, st, wb, flags, s1, s2, sj});
  endtask

  task automatic load_table();
    // register, word and immediate forms
    add_row(32'h007302b3, 12'h001, 8'h00, 7'h00, 4'h0, 3'h1, 9'h008, O_RS1, O_RS2, O_ZERO);
    add_row(32'h407302b3, 12'h002, 8'h00, 7'h00, 4'h0, 3'h1, 9'h008, O_RS1, O_RS2, O_ZERO);
    add_row(32'h407352b3, 12'h200, 8'h00, 7'h00, 4'h0, 3'h1, 9'h008, O_RS1, O_RS2, O_ZERO);
    add_row(32'h407302bb, 12'h002, 8'h00, 7'h00, 4'h0, 3'h1, 9'h009, O_RS1, O_RS2, O_ZERO);
    add_row(32'h007312bb, 12'h080, 8'h00, 7'h00, 4'h0, 3'h1, 9'h009, O_RS1, O_RS2, O_ZERO);
    add_row(32'hffb30293, 12'h001, 8'h00, 7'h00, 4'h0, 3'h1, 9'h008, O_RS1, O_IMMI, O_ZERO);
    add_row(32'h7ff33293, 12'h008, 8'h00, 7'h00, 4'h0, 3'h1, 9'h008, O_RS1, O_IMMI, O_ZERO);
    add_row(32'h42135293, 12'h200, 8'h00, 7'h00, 4'h0, 3'h1, 9'h008, O_RS1, O_IMMI, O_ZERO);
    add_row(32'h80037293, 12'h040, 8'h00, 7'h00, 4'h0, 3'h1, 9'h008, O_RS1, O_IMMI, O_ZERO);
    add_row(32'h4033529b, 12'h200, 8'h00, 7'h00, 4'h0, 3'h1, 9'h009, O_RS1, O_IMMI, O_ZERO);
    add_row(32'h800012b7, 12'h001, 8'h00, 7'h00, 4'h0, 3'h1, 9'h008, O_ZERO, O_IMMU, O_ZERO);
    add_row(32'h12345297, 12'h001, 8'h00, 7'h00, 4'h0, 3'h1, 9'h008, O_PC, O_IMMU, O_ZERO);
    // loads and stores
    add_row(32'hff833283, 12'h001, 8'h00, 7'h08, 4'h0, 3'h2, 9'h00a, O_RS1, O_IMMI, O_ZERO);
    add_row(32'h01034283, 12'h001, 8'h00, 7'h10, 4'h0, 3'h2, 9'h00a, O_RS1, O_IMMI, O_ZERO);
    add_row(32'h00036283, 12'h001, 8'h00, 7'h40, 4'h0, 3'h2, 9'h00a, O_RS1, O_IMMI, O_ZERO);
    add_row(32'hfe732e23, 12'h001, 8'h00, 7'h00, 4'h4, 3'h0, 9'h004, O_RS1, O_IMMS, O_ZERO);
    add_row(32'h00733423, 12'h001, 8'h00, 7'h00, 4'h8, 3'h0, 9'h004, O_RS1, O_IMMS, O_ZERO);
    // branches also raise the subtract
    add_row(32'hfe7308e3, 12'h012, 8'h01, 7'h00, 4'h0, 3'h0, 9'h000, O_RS1, O_RS2, O_IMMB);
    add_row(32'h007370e3, 12'h00a, 8'h20, 7'h00, 4'h0, 3'h0, 9'h000, O_RS1, O_RS2, O_IMMB);
    add_row(32'h00734463, 12'h006, 8'h04, 7'h00, 4'h0, 3'h0, 9'h000, O_RS1, O_RS2, O_IMMB);
    add_row(32'h100000ef, 12'h001, 8'h80, 7'h00, 4'h0, 3'h1, 9'h008, O_PC, O_FOUR, O_IMMJ);
    add_row(32'hffdff2ef, 12'h001, 8'h80, 7'h00, 4'h0, 3'h1, 9'h008, O_PC, O_FOUR, O_IMMJ);
    add_row(32'h00c300e7, 12'h001, 8'h40, 7'h00, 4'h0, 3'h1, 9'h008, O_PC, O_FOUR, O_IMMI);
    // csr, system and illegal words
    add_row(32'h300312f3, 12'h800, 8'h00, 7'h00, 4'h0, 3'h4, 9'h018, O_RS1, O_CSR, O_ZERO);
    add_row(32'h341322f3, 12'h020, 8'h00, 7'h00, 4'h0, 3'h4, 9'h018, O_RS1, O_CSR, O_ZERO);
    add_row(32'h305ff2f3, 12'h400, 8'h00, 7'h00, 4'h0, 3'h4, 9'h018, O_ZIMM, O_CSR, O_ZERO);
    add_row(32'h340552f3, 12'h800, 8'h00, 7'h00, 4'h0, 3'h4, 9'h018, O_ZIMM, O_CSR, O_ZERO);
    add_row(32'h00000073, 12'h000, 8'h00, 7'h00, 4'h0, 3'h0, 9'h100, O_ZERO, O_ZERO, O_ZERO);
    add_row(32'h00100073, 12'h000, 8'h00, 7'h00, 4'h0, 3'h0, 9'h080, O_ZERO, O_ZERO, O_ZERO);
    add_row(32'h30200073, 12'h000, 8'h00, 7'h00, 4'h0, 3'h0, 9'h040, O_ZERO, O_ZERO, O_ZERO);
    add_row(32'h0000007b, 12'h000, 8'h00, 7'h00, 4'h0, 3'h0, 9'h020, O_ZERO, O_ZERO, O_ZERO);
    add_row(32'h0000000f, 12'h000, 8'h00, 7'h00, 4'h0, 3'h0, 9'h020, O_ZERO, O_ZERO, O_ZERO);
  endtask

  task automatic check_row(input row_t r, input xlen_t pc);
    check("id_to_ex_valid", id_to_ex_valid, 1'b1);
    check("id_to_ex_pc", id_to_ex_pc, pc);
    check("alu_op", alu_op, r.alu);
    check("bj_op", bj_op, r.bj);
    check("load_op", load_op, r.ld);
    check("store_op", store_op, r.st);
    check("wb_sel", wb_sel, r.wb);
    check("is_word", is_word, r.flags[0]);
    check("mem_rd_ena", mem_rd_ena, r.flags[1]);
    check("mem_wr_ena", mem_wr_ena, r.flags[2]);
    check("reg_wr_ena", reg_wr_ena, r.flags[3]);
    check("csr_rd_ena", csr_rd_ena, r.flags[4]);
    check("csr_wr_ena", csr_wr_ena, r.flags[4]);
    check("inst_illegal", inst_illegal, r.flags[5]);
    check("excp_exit", excp_exit, r.flags[6]);
    check("excp_info", excp_info, r.flags[8:7]);
    check("reg_wr_addr", reg_wr_addr, r.flags[3] ? r.inst[11:7] : 5'd0);
    check("csr_rd_addr", csr_rd_addr, r.flags[4] ? r.inst[31:20] : 12'd0);
    check("csr_wr_addr", csr_wr_addr, r.flags[4] ? r.inst[31:20] : 12'd0);
    // jalr reads rs1 although op1 carries the pc
    check("rs1_addr", rs1_addr,
          (r.op1 == O_RS1 || r.jmp == O_IMMI) ? r.inst[19:15] : 5'd0);
    check("rs2_addr", rs2_addr,
          (r.op2 == O_RS2 || r.st != 0) ? r.inst[24:20] : 5'd0);
    check("op1", op1, expect_operand(r.op1, r.inst, pc));
    check("op2", op2, expect_operand(r.op2, r.inst, pc));
    check("jmp_imm", jmp_imm, expect_operand(r.jmp, r.inst, pc));
  endtask

  initial begin : watchdog
    wait (table_ready);
    repeat ((rows.size() + 4) * 20 + 16) @(posedge clk);
    $display("timeout: the test sequence did not complete in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : main
    row_t    r;
    xlen_t   pc;

    seed = 32'hece03c26;
    rst = 1'b1;
    if_to_id_valid = 1'b0;
    if_to_id_pc = '0;
    if_to_id_inst = '0;
    ex_allowin = 1'b1;
    bj_flush = 1'b0;
    rs1_data = {$random(seed), $random(seed)};
    rs2_data = {$random(seed), $random(seed)};
    csr_data = {$random(seed), $random(seed)};
    load_table();
    table_ready = 1'b1;

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check("id_to_ex_valid", id_to_ex_valid, 1'b0);
    check("mem_rd_ena", mem_rd_ena, 1'b0);
    check("mem_wr_ena", mem_wr_ena, 1'b0);
    check("reg_wr_ena", reg_wr_ena, 1'b0);
    check("csr_rd_ena", csr_rd_ena, 1'b0);
    check("csr_wr_ena", csr_wr_ena, 1'b0);
    check("excp_info", excp_info, 2'b00);

    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      cur_row = i;
      pc = 64'h8000_0000 + 64'(i * 4);
      while (!id_allowin) @(negedge clk);
      @(posedge clk);
      if_to_id_valid <= 1'b1;
      if_to_id_pc <= pc;
      if_to_id_inst <= r.inst;
      @(posedge clk);
      if_to_id_valid <= 1'b0;
      @(negedge clk);
      check_row(r, pc);
    end

    // stall with a second word waiting at the input
    cur_row = rows.size();
    @(posedge clk);
    ex_allowin <= 1'b0;
    if_to_id_valid <= 1'b1;
    if_to_id_pc <= 64'h9000_0000;
    if_to_id_inst <= 32'h407302b3;
    @(posedge clk);
    if_to_id_pc <= 64'h9000_0004;
    if_to_id_inst <= 32'h007302b3;
    @(negedge clk);
    check("alu_op", alu_op, 12'h002);
    repeat (4) begin
      @(negedge clk);
      check("id_allowin", id_allowin, 1'b0);
      check("id_to_ex_valid", id_to_ex_valid, 1'b1);
      check("id_to_ex_pc", id_to_ex_pc, 64'h9000_0000);
      check("alu_op", alu_op, 12'h002);
      check("op1", op1, rs1_data);
      check("op2", op2, rs2_data);
    end

    @(posedge clk);
    bj_flush <= 1'b1;
    @(negedge clk);
    check("id_to_ex_valid", id_to_ex_valid, 1'b0);
    @(posedge clk);
    bj_flush <= 1'b0;
    if_to_id_valid <= 1'b0;
    ex_allowin <= 1'b1;
    @(negedge clk);
    check("id_to_ex_valid", id_to_ex_valid, 1'b0);
    check("id_allowin", id_allowin, 1'b1);
    check("reg_wr_ena", reg_wr_ena, 1'b0);
    check("inst_illegal", inst_illegal, 1'b0);

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
